// File: logic/prio_cfg.svh
/*
 * calc2 command priority stage configuration
 * widths, port count and issue queue depth
 */
`ifndef PRIO_CFG_SVH
`define PRIO_CFG_SVH

// command, request tag and operand widths as seen on the hold ports
`define PRIO_CMD_W 4
`define PRIO_TAG_W 2
`define PRIO_DATA_W 32

// four request ports, so the port id needs two bits
`define PRIO_NUM_PORTS 4
`define PRIO_PORT_W 2

// entries held by each of the adder and shifter queues
`define PRIO_QUEUE_DEPTH 16

`endif

// File: logic/calc_cmd_pkg.sv
/*
 * calc2 command interface types
 * opcode encoding, request tag, operand and dispatched tag
 */
`include "prio_cfg.svh"

package calc_cmd_pkg;

   // only these five encodings are legal, anything else is reported as invalid
   typedef enum logic [`PRIO_CMD_W-1:0] {
      OP_NONE = 0,
      OP_ADD  = 1,
      OP_SUB  = 2,
      OP_SHL  = 5,
      OP_SHR  = 6
   } opcode_e;

   typedef logic [`PRIO_TAG_W-1:0] req_tag_t;

   typedef logic [`PRIO_DATA_W-1:0] operand_t;

   // port id in the upper bits, request tag in the lower bits
   typedef logic [`PRIO_PORT_W+`PRIO_TAG_W-1:0] out_tag_t;

endpackage

// File: logic/prio_queue_pkg.sv
/*
 * calc2 issue queue types
 * port id, queue entry layout, occupancy count and request vector
 */
`include "prio_cfg.svh"

package prio_queue_pkg;

   // port 1 is id 0
   typedef logic [`PRIO_PORT_W-1:0] port_id_t;

   // command, out tag, operand 1, operand 2 from msb down
   typedef logic [`PRIO_CMD_W+`PRIO_PORT_W+`PRIO_TAG_W+2*`PRIO_DATA_W-1:0] queue_entry_t;

   // one more bit than the slot index so a full queue can be counted
   typedef logic [$clog2(`PRIO_QUEUE_DEPTH+1)-1:0] queue_count_t;

   typedef logic [`PRIO_NUM_PORTS-1:0] port_req_t;

endpackage

// File: logic/port_decode.sv
/*
 * per-port command decoder
 * routes add/sub and shift commands, flags any other opcode one cycle later
 */
`timescale 1ns/1ps

module port_decode (
   input  logic                  c_clk,
   input  logic                  rst_n,
   input  calc_cmd_pkg::opcode_e cmd,
   input  calc_cmd_pkg::req_tag_t tag,
   output logic                  add_req,
   output logic                  shift_req,
   output logic                  invalid_op,
   output calc_cmd_pkg::req_tag_t invalid_tag
);

   import calc_cmd_pkg::*;

   logic is_invalid;

   assign add_req    = (cmd == OP_ADD) || (cmd == OP_SUB);
   assign shift_req  = (cmd == OP_SHL) || (cmd == OP_SHR);

   // a zero command is simply an idle port
   assign is_invalid = (cmd != OP_NONE) && !add_req && !shift_req;

   // the report lasts one cycle and carries the offending request tag
   always_ff @(posedge c_clk) begin
      if (!rst_n) begin
         invalid_op  <= 1'b0;
         invalid_tag <= '0;
      end else begin
         invalid_op  <= is_invalid;
         invalid_tag <= is_invalid ? tag : '0;
      end
   end

endmodule

// File: logic/issue_queue.sv
/*
 * in-order issue queue for one execution unit
 * appends up to one entry per port each cycle, shows its head for one cycle
 */
`timescale 1ns/1ps
`include "prio_cfg.svh"

module issue_queue #(
   parameter int DEPTH = `PRIO_QUEUE_DEPTH
) (
   input  logic                         c_clk,
   input  logic                         rst_n,
   input  prio_queue_pkg::port_req_t    req,
   input  prio_queue_pkg::queue_entry_t entry [`PRIO_NUM_PORTS],
   output calc_cmd_pkg::opcode_e        head_cmd,
   output calc_cmd_pkg::out_tag_t       head_tag,
   output calc_cmd_pkg::operand_t       head_data1,
   output calc_cmd_pkg::operand_t       head_data2,
   output logic                         head_vld
);

   import calc_cmd_pkg::*;
   import prio_queue_pkg::*;

   queue_entry_t slot     [DEPTH];
   queue_entry_t slot_nxt [DEPTH];
   queue_count_t ins_pos  [`PRIO_NUM_PORTS];
   queue_count_t count;
   queue_count_t count_nxt;
   logic         pop;

   logic [`PRIO_CMD_W-1:0] head_cmd_raw;

   // whatever sat in slot 0 during this cycle has been taken by the unit
   assign pop = (count != '0);

   // lower-numbered ports land first, right behind the surviving entries
   always_comb begin
      queue_count_t pos;
      pos = count - queue_count_t'(pop);
      for (int p = 0; p < `PRIO_NUM_PORTS; p++) begin
         ins_pos[p] = pos;
         pos = pos + queue_count_t'(req[p]);
      end
      count_nxt = pos;
   end

   // since a non-empty queue always pops, every slot moves down by one
   // unless a new entry is written into it
   always_comb begin
      for (int i = 0; i < DEPTH - 1; i++) begin
         slot_nxt[i] = slot[i + 1];
      end
      slot_nxt[DEPTH - 1] = slot[DEPTH - 1];
      for (int i = 0; i < DEPTH; i++) begin
         for (int p = 0; p < `PRIO_NUM_PORTS; p++) begin
            if (req[p] && (ins_pos[p] == queue_count_t'(i))) begin
               slot_nxt[i] = entry[p];
            end
         end
      end
   end

   always_ff @(posedge c_clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         slot[i] <= slot_nxt[i];
      end
   end

   always_ff @(posedge c_clk) begin
      if (!rst_n) begin
         count <= '0;
      end else begin
         count <= count_nxt;
      end
   end

   // slot 0 feeds the unit directly
   assign {head_cmd_raw, head_tag, head_data1, head_data2} = slot[0];
   assign head_cmd = opcode_e'(head_cmd_raw);
   assign head_vld = (count != '0);

endmodule

// File: logic/prio_dispatch.sv
/*
 * calc2 command priority stage
 * decodes four request ports into in-order adder and shifter issue queues
 */
`timescale 1ns/1ps
`include "prio_cfg.svh"

module prio_dispatch (
   input  logic                   c_clk,
   input  logic                   rst_n,

   input  logic [`PRIO_CMD_W-1:0] hold1_cmd,
   input  logic [`PRIO_CMD_W-1:0] hold2_cmd,
   input  logic [`PRIO_CMD_W-1:0] hold3_cmd,
   input  logic [`PRIO_CMD_W-1:0] hold4_cmd,
   input  calc_cmd_pkg::req_tag_t hold1_tag,
   input  calc_cmd_pkg::req_tag_t hold2_tag,
   input  calc_cmd_pkg::req_tag_t hold3_tag,
   input  calc_cmd_pkg::req_tag_t hold4_tag,
   input  calc_cmd_pkg::operand_t hold1_data1,
   input  calc_cmd_pkg::operand_t hold2_data1,
   input  calc_cmd_pkg::operand_t hold3_data1,
   input  calc_cmd_pkg::operand_t hold4_data1,
   input  calc_cmd_pkg::operand_t hold1_data2,
   input  calc_cmd_pkg::operand_t hold2_data2,
   input  calc_cmd_pkg::operand_t hold3_data2,
   input  calc_cmd_pkg::operand_t hold4_data2,

   output calc_cmd_pkg::opcode_e  prio_adder_cmd,
   output calc_cmd_pkg::out_tag_t prio_adder_tag,
   output calc_cmd_pkg::operand_t prio_adder_data1,
   output calc_cmd_pkg::operand_t prio_adder_data2,
   output logic                   prio_adder_out_vld,

   output calc_cmd_pkg::opcode_e  prio_shift_cmd,
   output calc_cmd_pkg::out_tag_t prio_shift_tag,
   output calc_cmd_pkg::operand_t prio_shift_data1,
   output calc_cmd_pkg::operand_t prio_shift_data2,
   output logic                   prio_shift_out_vld,

   output logic                   port1_invalid_op,
   output logic                   port2_invalid_op,
   output logic                   port3_invalid_op,
   output logic                   port4_invalid_op,
   output calc_cmd_pkg::req_tag_t port1_invalid_tag,
   output calc_cmd_pkg::req_tag_t port2_invalid_tag,
   output calc_cmd_pkg::req_tag_t port3_invalid_tag,
   output calc_cmd_pkg::req_tag_t port4_invalid_tag
);

   import calc_cmd_pkg::*;
   import prio_queue_pkg::*;

   logic [`PRIO_CMD_W-1:0] hold_cmd [`PRIO_NUM_PORTS];
   req_tag_t               hold_tag [`PRIO_NUM_PORTS];
   operand_t               hold_d1  [`PRIO_NUM_PORTS];
   operand_t               hold_d2  [`PRIO_NUM_PORTS];

   port_req_t              add_req;
   port_req_t              shift_req;
   port_req_t              invalid_op;
   req_tag_t               invalid_tag [`PRIO_NUM_PORTS];
   queue_entry_t           entry       [`PRIO_NUM_PORTS];

   assign hold_cmd = '{hold1_cmd, hold2_cmd, hold3_cmd, hold4_cmd};
   assign hold_tag = '{hold1_tag, hold2_tag, hold3_tag, hold4_tag};
   assign hold_d1  = '{hold1_data1, hold2_data1, hold3_data1, hold4_data1};
   assign hold_d2  = '{hold1_data2, hold2_data2, hold3_data2, hold4_data2};

   for (genvar i = 0; i < `PRIO_NUM_PORTS; i++) begin : g_port
      port_decode u_decode (
         .c_clk       (c_clk),
         .rst_n       (rst_n),
         .cmd         (opcode_e'(hold_cmd[i])),
         .tag         (hold_tag[i]),
         .add_req     (add_req[i]),
         .shift_req   (shift_req[i]),
         .invalid_op  (invalid_op[i]),
         .invalid_tag (invalid_tag[i])
      );

      // the same entry goes to both queues, the request bits pick the queue
      assign entry[i] = {hold_cmd[i], out_tag_t'({port_id_t'(i), hold_tag[i]}),
                         hold_d1[i], hold_d2[i]};
   end

   issue_queue #(.DEPTH(`PRIO_QUEUE_DEPTH)) u_add_queue (
      .c_clk      (c_clk),
      .rst_n      (rst_n),
      .req        (add_req),
      .entry      (entry),
      .head_cmd   (prio_adder_cmd),
      .head_tag   (prio_adder_tag),
      .head_data1 (prio_adder_data1),
      .head_data2 (prio_adder_data2),
      .head_vld   (prio_adder_out_vld)
   );

   issue_queue #(.DEPTH(`PRIO_QUEUE_DEPTH)) u_shift_queue (
      .c_clk      (c_clk),
      .rst_n      (rst_n),
      .req        (shift_req),
      .entry      (entry),
      .head_cmd   (prio_shift_cmd),
      .head_tag   (prio_shift_tag),
      .head_data1 (prio_shift_data1),
      .head_data2 (prio_shift_data2),
      .head_vld   (prio_shift_out_vld)
   );

   assign {port4_invalid_op, port3_invalid_op, port2_invalid_op, port1_invalid_op} = invalid_op;

   assign port1_invalid_tag = invalid_tag[0];
   assign port2_invalid_tag = invalid_tag[1];
   assign port3_invalid_tag = invalid_tag[2];
   assign port4_invalid_tag = invalid_tag[3];

endmodule

// File: test/prio_dispatch_checker.sv
/*
 * concurrent checks on the issue queues and the priority stage outputs
 */
`timescale 1ns/1ps
`include "prio_cfg.svh"

module issue_queue_checker #(
   parameter int DEPTH = `PRIO_QUEUE_DEPTH
) (
   input logic                       c_clk,
   input logic                       rst_n,
   input logic [$clog2(DEPTH+1)-1:0] count,
   input logic                       head_vld,
   input logic [`PRIO_CMD_W-1:0]     head_cmd
);

   import calc_cmd_pkg::*;

   a_count_limit : assert property (@(posedge c_clk) disable iff (!rst_n)
      count <= DEPTH) else $error("issue queue holds more than its depth");

   a_vld_cmd : assert property (@(posedge c_clk) disable iff (!rst_n)
      head_vld |-> head_cmd != OP_NONE) else $error("valid head with a zero command");

   // the head still carries its reset value on the first edge out of reset
   a_reset_quiet : assert property (@(posedge c_clk)
      $rose(rst_n) |-> !head_vld)
      else $error("queue head valid right after reset");

endmodule

module prio_dispatch_checker (
   input logic                                   c_clk,
   input logic                                   rst_n,
   input prio_queue_pkg::port_req_t              invalid_op,
   input logic [`PRIO_NUM_PORTS*`PRIO_CMD_W-1:0] port_cmd
);

   import calc_cmd_pkg::*;

   // invalid reports still carry their reset values on the first edge out of reset
   a_reset_quiet : assert property (@(posedge c_clk)
      $rose(rst_n) |-> (invalid_op == '0))
      else $error("invalid opcode reported right after reset");

   for (genvar p = 0; p < `PRIO_NUM_PORTS; p++) begin : g_inv
      a_inv_legal : assert property (@(posedge c_clk) disable iff (!rst_n)
         invalid_op[p] |-> !($past(port_cmd[p*`PRIO_CMD_W +: `PRIO_CMD_W])
                             inside {OP_ADD, OP_SUB, OP_SHL, OP_SHR}))
         else $error("invalid opcode flagged for a legal command");
   end

endmodule

bind issue_queue issue_queue_checker #(.DEPTH(DEPTH)) u_queue_checker (
   .c_clk(c_clk), .rst_n(rst_n), .count(count), .head_vld(head_vld),
   .head_cmd(head_cmd)
);

bind prio_dispatch prio_dispatch_checker u_top_checker (
   .c_clk(c_clk), .rst_n(rst_n),
   .invalid_op({port4_invalid_op, port3_invalid_op, port2_invalid_op, port1_invalid_op}),
   .port_cmd({hold4_cmd, hold3_cmd, hold2_cmd, hold1_cmd})
);

// File: test/tb_prio_dispatch.sv
/*
 * testbench for the calc2 command priority stage
 * directed tests checked cycle by cycle against a model of both issue queues
 */
`timescale 1ns/1ps
`include "prio_cfg.svh"

module tb_prio_dispatch;

   import calc_cmd_pkg::*;
   import prio_queue_pkg::*;

   localparam int NP = `PRIO_NUM_PORTS;
   localparam int DEPTH = `PRIO_QUEUE_DEPTH;
   localparam int RANDOM_CYCLES = 300;
   // reset, five short tests with their drains, the random stream and its drain, with margin
   localparam int TIMEOUT_CYCLES = 8 + 5 * 60 + RANDOM_CYCLES * 2 + 100;

   logic                   c_clk;
   logic                   rst_n;
   logic [`PRIO_CMD_W-1:0] hold_cmd [NP];
   req_tag_t               hold_tag [NP];
   operand_t               hold_d1  [NP];
   operand_t               hold_d2  [NP];
   opcode_e                add_cmd, shift_cmd;
   out_tag_t               add_tag, shift_tag;
   operand_t               add_d1, add_d2, shift_d1, shift_d2;
   logic                   add_vld, shift_vld;
   logic                   inv_op  [NP];
   req_tag_t               inv_tag [NP];

   queue_entry_t add_q[$];
   queue_entry_t shift_q[$];
   logic         exp_inv     [NP];
   req_tag_t     exp_inv_tag [NP];
   logic         armed = 1'b0;
   string        test_name = "reset";
   int           mismatches = 0;
   int           other_errors = 0;
   int           cycles = 0;

   prio_dispatch u_prio_dispatch (
      .c_clk(c_clk), .rst_n(rst_n),
      .hold1_cmd(hold_cmd[0]), .hold2_cmd(hold_cmd[1]),
      .hold3_cmd(hold_cmd[2]), .hold4_cmd(hold_cmd[3]),
      .hold1_tag(hold_tag[0]), .hold2_tag(hold_tag[1]),
      .hold3_tag(hold_tag[2]), .hold4_tag(hold_tag[3]),
      .hold1_data1(hold_d1[0]), .hold2_data1(hold_d1[1]),
      .hold3_data1(hold_d1[2]), .hold4_data1(hold_d1[3]),
      .hold1_data2(hold_d2[0]), .hold2_data2(hold_d2[1]),
      .hold3_data2(hold_d2[2]), .hold4_data2(hold_d2[3]),
      .prio_adder_cmd(add_cmd), .prio_adder_tag(add_tag),
      .prio_adder_data1(add_d1), .prio_adder_data2(add_d2), .prio_adder_out_vld(add_vld),
      .prio_shift_cmd(shift_cmd), .prio_shift_tag(shift_tag),
      .prio_shift_data1(shift_d1), .prio_shift_data2(shift_d2),
      .prio_shift_out_vld(shift_vld),
      .port1_invalid_op(inv_op[0]), .port2_invalid_op(inv_op[1]),
      .port3_invalid_op(inv_op[2]), .port4_invalid_op(inv_op[3]),
      .port1_invalid_tag(inv_tag[0]), .port2_invalid_tag(inv_tag[1]),
      .port3_invalid_tag(inv_tag[2]), .port4_invalid_tag(inv_tag[3])
   );

   always #20 c_clk = ~c_clk;

   always @(posedge c_clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Testbench failed");
         $finish;
      end
   end

   task automatic check_cmd(string what, opcode_e exp, opcode_e act);
      if (exp !== act) begin
         $display("MISMATCH %s %s: expected %0d actual %0d", test_name, what, exp, act);
         mismatches++;
      end
   endtask

   task automatic check_tag(string what, out_tag_t exp, out_tag_t act);
      if (exp !== act) begin
         $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
         mismatches++;
      end
   endtask

   task automatic check_data(string what, operand_t exp, operand_t act);
      if (exp !== act) begin
         $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
         mismatches++;
      end
   endtask

   task automatic check_bit(string what, logic exp, logic act);
      if (exp !== act) begin
         $display("MISMATCH %s %s: expected %b actual %b", test_name, what, exp, act);
         mismatches++;
      end
   endtask

   // model: a shown head is gone at the next edge, then new commands join in port order
   always @(posedge c_clk) begin
      armed = 1'b1;
      if (!rst_n) begin
         add_q.delete();
         shift_q.delete();
         for (int p = 0; p < NP; p++) begin
            exp_inv[p] = 1'b0;
            exp_inv_tag[p] = '0;
         end
      end else begin
         if (add_q.size() > 0)
            void'(add_q.pop_front());
         if (shift_q.size() > 0)
            void'(shift_q.pop_front());
         for (int p = 0; p < NP; p++) begin
            exp_inv[p] = 1'b0;
            exp_inv_tag[p] = hold_tag[p];
            case (hold_cmd[p])
               4'd0: ;
               4'd1, 4'd2:
                  add_q.push_back({hold_cmd[p], port_id_t'(p), hold_tag[p],
                                   hold_d1[p], hold_d2[p]});
               4'd5, 4'd6:
                  shift_q.push_back({hold_cmd[p], port_id_t'(p), hold_tag[p],
                                     hold_d1[p], hold_d2[p]});
               default: exp_inv[p] = 1'b1;
            endcase
         end
      end
   end

   task automatic compare_head(string unit, queue_entry_t q[$], logic vld, opcode_e cmd,
                               out_tag_t tag, operand_t d1, operand_t d2);
      logic [`PRIO_CMD_W-1:0] c;
      out_tag_t t;
      operand_t a;
      operand_t b;
      check_bit({unit, " out_vld"}, q.size() > 0, vld);
      if (q.size() > 0 && vld) begin
         {c, t, a, b} = q[0];
         check_cmd({unit, " cmd"}, opcode_e'(c), cmd);
         check_tag({unit, " tag"}, t, tag);
         check_data({unit, " data1"}, a, d1);
         check_data({unit, " data2"}, b, d2);
      end
   endtask

   always @(negedge c_clk) begin
      if (armed) begin
         compare_head("adder", add_q, add_vld, add_cmd, add_tag, add_d1, add_d2);
         compare_head("shifter", shift_q, shift_vld, shift_cmd, shift_tag, shift_d1, shift_d2);
         for (int p = 0; p < NP; p++) begin
            check_bit($sformatf("port%0d invalid_op", p + 1), exp_inv[p], inv_op[p]);
            if (exp_inv[p] && inv_op[p])
               check_tag($sformatf("port%0d invalid_tag", p + 1),
                         out_tag_t'(exp_inv_tag[p]), out_tag_t'(inv_tag[p]));
         end
      end
   end

   task automatic clear_ports();
      for (int p = 0; p < NP; p++) begin
         hold_cmd[p] <= '0;
         hold_tag[p] <= '0;
         hold_d1[p] <= '0;
         hold_d2[p] <= '0;
      end
   endtask

   task automatic offer(int p, logic [`PRIO_CMD_W-1:0] cmd, req_tag_t tag,
                        operand_t d1, operand_t d2);
      hold_cmd[p] <= cmd;
      hold_tag[p] <= tag;
      hold_d1[p] <= d1;
      hold_d2[p] <= d2;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((add_q.size() > 0 || shift_q.size() > 0 || add_vld || shift_vld) && n < 60) begin
         @(negedge c_clk);
         n++;
      end
      if (n >= 60) begin
         $display("%s: the queues did not drain within 60 cycles", test_name);
         other_errors++;
      end
   endtask

   task automatic test_reset_idle();
      test_name = "reset_idle";
      @(posedge c_clk);
      clear_ports();
      repeat (6) begin
         @(negedge c_clk);
         check_bit("adder out_vld", 1'b0, add_vld);
         check_bit("shifter out_vld", 1'b0, shift_vld);
         for (int p = 0; p < NP; p++)
            check_bit("invalid_op", 1'b0, inv_op[p]);
      end
   endtask

   task automatic test_single_sub();
      test_name = "single_sub";
      @(posedge c_clk);
      offer(2, 4'd2, 2'b11, 32'h1234_5678, 32'h0bad_cafe);
      @(posedge c_clk);
      clear_ports();
      @(negedge c_clk);
      check_bit("adder out_vld", 1'b1, add_vld);
      check_cmd("adder cmd", OP_SUB, add_cmd);
      check_tag("adder tag", 4'hb, add_tag);
      check_data("adder data1", 32'h1234_5678, add_d1);
      check_data("adder data2", 32'h0bad_cafe, add_d2);
      check_bit("shifter out_vld", 1'b0, shift_vld);
      @(negedge c_clk);
      check_bit("adder out_vld", 1'b0, add_vld);
   endtask

   task automatic test_port_order();
      test_name = "port_order";
      @(posedge c_clk);
      for (int p = 0; p < NP; p++)
         offer(p, 4'd1, req_tag_t'(3 - p), 32'(p), 32'(p + 16));
      @(posedge c_clk);
      clear_ports();
      for (int p = 0; p < NP; p++) begin
         @(negedge c_clk);
         check_bit("adder out_vld", 1'b1, add_vld);
         check_tag("adder tag", out_tag_t'({p[1:0], 2'(3 - p)}), add_tag);
         check_data("adder data1", 32'(p), add_d1);
      end
      @(negedge c_clk);
      check_bit("adder out_vld", 1'b0, add_vld);
   endtask

   task automatic test_parallel_units();
      test_name = "parallel_units";
      @(posedge c_clk);
      offer(0, 4'd1, 2'd0, 32'haaaa_0001, 32'h1);
      offer(1, 4'd5, 2'd1, 32'hbbbb_0002, 32'h2);
      offer(2, 4'd2, 2'd2, 32'hcccc_0003, 32'h3);
      offer(3, 4'd6, 2'd3, 32'hdddd_0004, 32'h4);
      @(posedge c_clk);
      offer(0, 4'd6, 2'd1, 32'h5, 32'h6);
      offer(1, 4'd2, 2'd2, 32'h7, 32'h8);
      offer(2, 4'd0, 2'd0, 32'h0, 32'h0);
      offer(3, 4'd5, 2'd0, 32'h9, 32'ha);
      @(posedge c_clk);
      clear_ports();
      @(negedge c_clk);
      check_bit("adder out_vld", 1'b1, add_vld);
      check_bit("shifter out_vld", 1'b1, shift_vld);
      wait_drain();
   endtask

   task automatic test_invalid_ops();
      test_name = "invalid_ops";
      @(posedge c_clk);
      offer(1, 4'd3, 2'd1, 32'h11, 32'h22);
      @(posedge c_clk);
      offer(1, 4'd15, 2'd2, 32'h33, 32'h44);
      @(negedge c_clk);
      check_bit("port2 invalid_op", 1'b1, inv_op[1]);
      check_tag("port2 invalid_tag", 4'd1, out_tag_t'(inv_tag[1]));
      @(posedge c_clk);
      clear_ports();
      @(negedge c_clk);
      check_bit("port2 invalid_op", 1'b1, inv_op[1]);
      check_tag("port2 invalid_tag", 4'd2, out_tag_t'(inv_tag[1]));
      @(negedge c_clk);
      check_bit("port2 invalid_op", 1'b0, inv_op[1]);
      check_bit("adder out_vld", 1'b0, add_vld);
      check_bit("shifter out_vld", 1'b0, shift_vld);
   endtask

   task automatic test_random_stream();
      logic [`PRIO_CMD_W-1:0] pick [8];
      logic busy;
      pick = '{4'd0, 4'd0, 4'd1, 4'd2, 4'd5, 4'd6, 4'd3, 4'd15};
      test_name = "random_stream";
      repeat (RANDOM_CYCLES) begin
         @(negedge c_clk);
         // keep room for two more cycles of four requests each
         busy = (add_q.size() > DEPTH - 8) || (shift_q.size() > DEPTH - 8);
         @(posedge c_clk);
         clear_ports();
         if (!busy) begin
            for (int p = 0; p < NP; p++)
               offer(p, pick[$urandom % 8], req_tag_t'($urandom), $urandom, $urandom);
         end
      end
      @(posedge c_clk);
      clear_ports();
      wait_drain();
   endtask

   initial begin
      c_clk = 1'b0;
      rst_n = 1'b0;
      for (int p = 0; p < NP; p++) begin
         hold_cmd[p] = '0;
         hold_tag[p] = '0;
         hold_d1[p] = '0;
         hold_d2[p] = '0;
      end
      void'($urandom(32'hafb1_ab1c));
      repeat (8) @(posedge c_clk);
      rst_n <= 1'b1;
      test_reset_idle();
      test_single_sub();
      test_port_order();
      test_parallel_units();
      test_invalid_ops();
      test_random_stream();
      repeat (2) @(negedge c_clk);
      $display("closing: %0d mismatches, %0d other errors", mismatches, other_errors);
      if (mismatches + other_errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// File: filelist.f
+incdir+logic
logic/calc_cmd_pkg.sv
logic/prio_queue_pkg.sv
logic/port_decode.sv
logic/issue_queue.sv
logic/prio_dispatch.sv
test/prio_dispatch_checker.sv
test/tb_prio_dispatch.sv

// File: run.sh
#!/bin/sh
# build and run the calc2 priority stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f filelist.f \
   --top-module tb_prio_dispatch \
   -o sim_prio_dispatch

if ! ./obj_dir/sim_prio_dispatch > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi

cat sim.log

if grep -q "Testbench failed" sim.log; then
   exit 1
fi
exit 0
